/* list.f */
+incdir+rtl
rtl/ExecPkg.sv
rtl/ResultBusIf.sv
rtl/IssueIf.sv
rtl/ReservationStation.sv
rtl/IntAlu.sv
rtl/ResultBusArbiter.sv
rtl/ExecCluster.sv
bench/ClockGen.sv
bench/ResultChecker.sv
bench/ClusterBench.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ExecPkg.sv
      - rtl/ResultBusIf.sv
      - rtl/IssueIf.sv
      - rtl/ReservationStation.sv
      - rtl/IntAlu.sv
      - rtl/ResultBusArbiter.sv
      - rtl/ExecCluster.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/ClockGen.sv
      - bench/ResultChecker.sv
      - bench/ClusterBench.sv

/* bench/ClusterBench.sv */
`timescale 1ns/1ps
`include "cluster_config.svh"

module ClusterBench;

    localparam int MAX_TAG        = (1 << `TAG_WIDTH) - 1;
    localparam int TOTAL_OPS      = 200 + 200 + 100 + 40 + 200;
    localparam int TIMEOUT_CYCLES = 60 * TOTAL_OPS;

    logic                         clk;
    logic                         rst;
    logic                         issueValid;
    logic                         issueStation;
    ExecPkg::OpCode               issueOpcode;
    logic [`TAG_WIDTH-1:0]        issueTagA;
    logic [`TAG_WIDTH-1:0]        issueTagB;
    logic [`TAG_WIDTH-1:0]        issueTagDst;
    logic [`DATA_WIDTH-1:0]       issueSrcA;
    logic [`DATA_WIDTH-1:0]       issueSrcB;
    logic [`DATA_WIDTH-1:0]       issueImm;
    logic [ExecPkg::NM_WIDTH-1:0] issueNmDst;
    logic [1:0]                   creditReturn;
    logic                         resultValid;
    logic [`TAG_WIDTH-1:0]        resultTag;
    logic [`DATA_WIDTH-1:0]       resultValue;
    logic [ExecPkg::NM_WIDTH-1:0] resultNmDst;
    logic                         testEnd;
    int                           testNum;
    int                           errorCount;
    int                           checkCount;

    logic [31:0] lfsrState;
    int          issuedSeq [MAX_TAG+1];  // Pending while issuedSeq differs from doneSeq
    int          doneSeq [MAX_TAG+1];
    int          issuedCnt [2];
    int          returnedCnt [2];
    int          nextTag;
    int          cycleCount;

    ClockGen      u_ClockGen (.clk(clk), .rst(rst));
    ExecCluster   u_ExecCluster (.*);
    ResultChecker u_ResultChecker (.*);

    // ################################################
    // Random source and dispatcher bookkeeping

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v         = {v[30:0], lfsrState[0]};
            lfsrState = galoisStep(lfsrState);
        end
        return v;
    endfunction

    function automatic bit isPending(input int t);
        return issuedSeq[t] != doneSeq[t];
    endfunction

    function automatic int credit(input int s);
        return `RS_SIZE - (issuedCnt[s] - returnedCnt[s]);
    endfunction

    function automatic bit anyOutstanding();
        for (int t = 1; t <= MAX_TAG; t++)
            if (isPending(t))
                return 1'b1;
        return issuedCnt[0] != returnedCnt[0] || issuedCnt[1] != returnedCnt[1];
    endfunction

    function automatic int pickPending();
        int cand [$];
        for (int t = 1; t <= MAX_TAG; t++)
            if (isPending(t))
                cand.push_back(t);
        if (cand.size() == 0)
            return 0;
        return cand[takeBits(6) % cand.size()];
    endfunction

    // Next nonzero tag with no op in flight
    function automatic int allocTag();
        for (int k = 0; k < MAX_TAG; k++) begin
            nextTag = (nextTag >= MAX_TAG) ? 1 : nextTag + 1;
            if (!isPending(nextTag))
                return nextTag;
        end
        return 0;
    endfunction

    function automatic int chooseSource(input int idx, input int lastTag);
        if (idx == 4)
            return isPending(lastTag) ? lastTag : 0;  // Serial chain fills the station
        if (idx == 2 && takeBits(1) == 1)
            return pickPending();
        if (idx == 3 && takeBits(2) == 0)
            return pickPending();
        return 0;
    endfunction

    task automatic runTest(input int idx, input int numOps);
        int          sent;
        int          st;
        int          lastTag;
        int          tagA;
        int          tagB;
        int          tagDst;
        logic        idle;
        logic [31:0] nmBits;
        sent    = 0;
        lastTag = 0;
        while (sent < numOps) begin
            @(posedge clk);
            #1;
            issueValid = 1'b0;
            idle       = (idx == 3) && (takeBits(2) == 0);  // Gaps in the mixed test
            st         = takeBits(1);
            if (idx == 4)
                st = (sent >= numOps / 2) ? 1 : 0;
            else if (credit(st) == 0)
                st = 1 - st;
            if (!idle && credit(st) > 0) begin
                issueOpcode  = ExecPkg::OpCode'(takeBits(3));
                issueSrcA    = takeBits(32);
                issueSrcB    = takeBits(32);
                issueImm     = takeBits(32);
                nmBits       = takeBits(ExecPkg::NM_WIDTH);
                issueNmDst   = nmBits[ExecPkg::NM_WIDTH-1:0];
                tagA         = chooseSource(idx, lastTag);
                tagB         = (idx == 4) ? 0 : chooseSource(idx, 0);
                tagDst       = allocTag();
                issueStation = st[0];
                issueTagA    = tagA[`TAG_WIDTH-1:0];
                issueTagB    = tagB[`TAG_WIDTH-1:0];
                issueTagDst  = tagDst[`TAG_WIDTH-1:0];
                issueValid   = 1'b1;
                issuedSeq[tagDst]++;
                issuedCnt[st]++;
                lastTag = tagDst;
                sent++;
            end
        end
        @(posedge clk);
        #1;
        issueValid = 1'b0;
        while (anyOutstanding())
            @(posedge clk);
        @(posedge clk);
        #1;
        testNum = idx;
        testEnd = 1'b1;
        @(posedge clk);
        #1;
        testEnd = 1'b0;
    endtask

    // Results and credits as the dispatcher sees them
    always @(negedge clk) begin
        if (!rst) begin
            if (resultValid)
                doneSeq[resultTag]++;
            for (int s = 0; s < 2; s++)
                if (creditReturn[s])
                    returnedCnt[s]++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        lfsrState    = 32'd33;
        nextTag      = 0;
        issueValid   = 1'b0;
        issueStation = 1'b0;
        issueOpcode  = ExecPkg::OpAdd;
        issueTagA    = '0;
        issueTagB    = '0;
        issueTagDst  = '0;
        issueSrcA    = '0;
        issueSrcB    = '0;
        issueImm     = '0;
        issueNmDst   = '0;
        testEnd      = 1'b0;
        testNum      = 0;
        @(negedge rst);
        runTest(1, 200);
        runTest(2, 200);
        runTest(3, 100);
        runTest(4, 40);
        runTest(5, 200);
        repeat (2) @(posedge clk);
        $display("Done: %0d results checked, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* bench/ResultChecker.sv */
`timescale 1ns/1ps
`include "cluster_config.svh"

module ResultChecker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issueValid,
    input  logic                         issueStation,
    input  ExecPkg::OpCode               issueOpcode,
    input  logic [`TAG_WIDTH-1:0]        issueTagA,
    input  logic [`TAG_WIDTH-1:0]        issueTagB,
    input  logic [`TAG_WIDTH-1:0]        issueTagDst,
    input  logic [`DATA_WIDTH-1:0]       issueSrcA,
    input  logic [`DATA_WIDTH-1:0]       issueSrcB,
    input  logic [`DATA_WIDTH-1:0]       issueImm,
    input  logic [ExecPkg::NM_WIDTH-1:0] issueNmDst,
    input  logic [1:0]                   creditReturn,
    input  logic                         resultValid,
    input  logic [`TAG_WIDTH-1:0]        resultTag,
    input  logic [`DATA_WIDTH-1:0]       resultValue,
    input  logic [ExecPkg::NM_WIDTH-1:0] resultNmDst,
    input  logic                         testEnd,
    input  int                           testNum,
    output int                           errorCount,
    output int                           checkCount
);

    localparam int NUM_TAGS = 1 << `TAG_WIDTH;

    logic [`DATA_WIDTH-1:0]       expVal [NUM_TAGS];  // Model result per tag
    logic [ExecPkg::NM_WIDTH-1:0] expNm [NUM_TAGS];
    bit                           inFlight [NUM_TAGS];
    bit                           stationOf [NUM_TAGS];
    int                           outstanding [2];    // Entries held per station
    int                           peak [2];
    int                           laneResults [2];
    int                           testErrors;
    int                           forwards;  // Operands met in their own issue cycle
    logic [7:0]                   opsSeen;
    logic [`DATA_WIDTH-1:0]       opA;
    logic [`DATA_WIDTH-1:0]       opB;

    // Reference ALU
    function automatic logic [`DATA_WIDTH-1:0] opResult(
        input ExecPkg::OpCode         op,
        input logic [`DATA_WIDTH-1:0] a,
        input logic [`DATA_WIDTH-1:0] b,
        input logic [`DATA_WIDTH-1:0] imm
    );
        case (op)
            ExecPkg::OpAdd: return a + b;
            ExecPkg::OpSub: return a - b;
            ExecPkg::OpAnd: return a & b;
            ExecPkg::OpOr:  return a | b;
            ExecPkg::OpXor: return a ^ b;
            ExecPkg::OpShl: return a << (b % 32);
            ExecPkg::OpShr: return a >> (b % 32);
            default:        return a + imm;  // OpAddImm
        endcase
    endfunction

    function automatic string testName(input int n);
        case (n)
            1:       return "independent";
            2:       return "chains";
            3:       return "completeness";
            4:       return "credits";
            default: return "contention";
        endcase
    endfunction

    task automatic noteError(input string msg);
        $display("%s", msg);
        errorCount++;
        testErrors++;
    endtask

    // ################################################
    // End-of-test checks after the cluster has drained

    task automatic finishTest();
        int left;
        int total;
        left  = 0;
        total = laneResults[0] + laneResults[1];
        for (int t = 0; t < NUM_TAGS; t++)
            if (inFlight[t])
                left++;
        if (left != 0)
            noteError($sformatf("%0d issued tags never came back on the result bus", left));
        for (int s = 0; s < 2; s++)
            if (outstanding[s] != 0)
                noteError($sformatf("Station %0d kept %0d credits after draining",
                                    s, outstanding[s]));
        if (testNum == 1 && opsSeen != 8'hFF)
            noteError("Not all eight opcodes were issued");
        if (testNum == 2 && forwards == 0)
            noteError("No operand was forwarded in its issue cycle");
        if (testNum == 4 && (peak[0] != `RS_SIZE || peak[1] != `RS_SIZE))
            noteError("A station was never filled to all of its entries");
        if (testNum == 5 && (laneResults[0] * 4 < total || laneResults[1] * 4 < total))
            noteError("One ALU was starved on the result bus");
        $display("Test %0d %s: %0d results, %0d same-cycle forwards, %0d errors, %s",
                 testNum, testName(testNum), total, forwards, testErrors,
                 (testErrors == 0) ? "ok" : "bad");
        testErrors = 0;
        forwards   = 0;
        opsSeen    = '0;
        for (int s = 0; s < 2; s++) begin
            peak[s]        = 0;
            laneResults[s] = 0;
        end
    endtask

    initial opsSeen = '0;

    // Sample mid-cycle where every port is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (resultValid) begin
                checkCount++;
                if (!inFlight[resultTag]) begin
                    noteError($sformatf("Tag %0d reached the result bus at %0t without being issued",
                                        resultTag, $time));
                end else begin
                    if (resultValue !== expVal[resultTag] || resultNmDst !== expNm[resultTag])
                        noteError($sformatf("FAIL at %0t: tag %0d gave %h r%0d, expected %h r%0d",
                                            $time, resultTag, resultValue, resultNmDst,
                                            expVal[resultTag], expNm[resultTag]));
                    inFlight[resultTag] = 1'b0;
                    laneResults[stationOf[resultTag]]++;
                end
            end

            for (int s = 0; s < 2; s++) begin
                if (creditReturn[s]) begin
                    if (outstanding[s] == 0)
                        noteError($sformatf("Station %0d returned a credit with nothing held", s));
                    else
                        outstanding[s]--;
                end
            end

            if (issueValid) begin
                opA = (issueTagA != '0) ? expVal[issueTagA] : issueSrcA;  // Producer's model value
                opB = (issueTagB != '0) ? expVal[issueTagB] : issueSrcB;
                if ((issueTagA != '0 && resultValid && resultTag == issueTagA) ||
                    (issueTagB != '0 && resultValid && resultTag == issueTagB))
                    forwards++;
                expVal[issueTagDst]    = opResult(issueOpcode, opA, opB, issueImm);
                expNm[issueTagDst]     = issueNmDst;
                inFlight[issueTagDst]  = 1'b1;
                stationOf[issueTagDst] = issueStation;
                opsSeen[issueOpcode]   = 1'b1;
                outstanding[issueStation]++;
                if (outstanding[issueStation] > peak[issueStation])
                    peak[issueStation] = outstanding[issueStation];
            end

            if (testEnd)
                finishTest();
        end
    end

endmodule

/* bench/ClockGen.sv */
`timescale 1ns/1ps

// Free-running clock and a reset held over the first two edges
module ClockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* rtl/ExecCluster.sv */
`timescale 1ns/1ps
`include "cluster_config.svh"

module ExecCluster (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issueValid,
    input  logic                         issueStation,  // Target station
    input  ExecPkg::OpCode               issueOpcode,
    input  logic [`TAG_WIDTH-1:0]        issueTagA,
    input  logic [`TAG_WIDTH-1:0]        issueTagB,
    input  logic [`TAG_WIDTH-1:0]        issueTagDst,
    input  logic [`DATA_WIDTH-1:0]       issueSrcA,
    input  logic [`DATA_WIDTH-1:0]       issueSrcB,
    input  logic [`DATA_WIDTH-1:0]       issueImm,
    input  logic [ExecPkg::NM_WIDTH-1:0] issueNmDst,
    output logic [1:0]                   creditReturn,
    output logic                         resultValid,
    output logic [`TAG_WIDTH-1:0]        resultTag,
    output logic [`DATA_WIDTH-1:0]       resultValue,
    output logic [ExecPkg::NM_WIDTH-1:0] resultNmDst
);

    ExecPkg::MicroOp    issueOp;
    logic [1:0]         aluReq;
    logic [1:0]         aluGrant;
    ExecPkg::ResultWord aluWord [2];

    ResultBusIf resultBus ();
    IssueIf     issueLink [2] ();

    // Pack the dispatcher fields
    always_comb begin
        issueOp        = '0;
        issueOp.valid  = issueValid;
        issueOp.opcode = issueOpcode;
        issueOp.tagA   = issueTagA;
        issueOp.srcA   = issueSrcA;
        issueOp.tagB   = issueTagB;
        issueOp.srcB   = issueSrcB;
        issueOp.imm    = issueImm;
        issueOp.tagDst = issueTagDst;
        issueOp.nmDst  = issueNmDst;
    end

    // ################################################
    // Two lanes of station plus ALU

    for (genvar g = 0; g < 2; g++) begin : g_Lane
        ReservationStation u_Station (
            .clk          (clk),
            .rst          (rst),
            .inValid      (issueValid && (issueStation == 1'(g))),
            .inOp         (issueOp),
            .bus          (resultBus),
            .issue        (issueLink[g]),
            .creditReturn (creditReturn[g])
        );

        IntAlu u_Alu (
            .clk    (clk),
            .rst    (rst),
            .issue  (issueLink[g]),
            .req    (aluReq[g]),
            .result (aluWord[g]),
            .grant  (aluGrant[g])
        );
    end

    ResultBusArbiter u_Arbiter (
        .clk   (clk),
        .rst   (rst),
        .req   (aluReq),
        .word  (aluWord),
        .grant (aluGrant),
        .bus   (resultBus)
    );

    // Bus straight out to the result ports
    assign resultValid = resultBus.word.valid;
    assign resultTag   = resultBus.word.tag;
    assign resultValue = resultBus.word.value;
    assign resultNmDst = resultBus.word.nmDst;

endmodule

/* rtl/ResultBusArbiter.sv */
`timescale 1ns/1ps

module ResultBusArbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         req,
    input  ExecPkg::ResultWord word [2],
    output logic [1:0]         grant,
    ResultBusIf.driver         bus
);

    logic               prio;     // High favors requester 1
    ExecPkg::ResultWord busWord;

    // ################################################
    // Grant, one requester per cycle

    always_comb begin
        if (req == 2'b11)
            grant = prio ? 2'b10 : 2'b01;
        else
            grant = req;
    end

    // ################################################
    // Priority rotation and bus register

    always_ff @(posedge clk) begin
        if (rst) begin
            prio          <= 1'b0;
            busWord.valid <= 1'b0;
        end else begin
            if (|grant)
                prio <= grant[0];  // Loser of this round goes first next

            if (grant[1])
                busWord <= word[1];
            else
                busWord <= word[0];
            busWord.valid <= |grant;  // Idle bus when nothing granted
        end
    end

    assign bus.word = busWord;

endmodule

/* rtl/IntAlu.sv */
`timescale 1ns/1ps
`include "cluster_config.svh"

module IntAlu (
    input  logic               clk,
    input  logic               rst,
    IssueIf.alu                issue,
    output logic               req,
    output ExecPkg::ResultWord result,
    input  logic               grant
);

    ExecPkg::ResultWord held;  // Single result slot
    logic               load;

    // Opcode function, shifts use the low five bits of srcB
    function automatic logic [`DATA_WIDTH-1:0] compute(input ExecPkg::MicroOp op);
        logic [`DATA_WIDTH-1:0] res;
        case (op.opcode)
            ExecPkg::OpAdd:    res = op.srcA + op.srcB;
            ExecPkg::OpSub:    res = op.srcA - op.srcB;
            ExecPkg::OpAnd:    res = op.srcA & op.srcB;
            ExecPkg::OpOr:     res = op.srcA | op.srcB;
            ExecPkg::OpXor:    res = op.srcA ^ op.srcB;
            ExecPkg::OpShl:    res = op.srcA << op.srcB[4:0];
            ExecPkg::OpShr:    res = op.srcA >> op.srcB[4:0];
            ExecPkg::OpAddImm: res = op.srcA + op.imm;
            default:           res = '0;
        endcase
        return res;
    endfunction

    // Slot is free when empty or leaving on this cycle's grant
    assign issue.ready = !held.valid || grant;
    assign load        = issue.valid && issue.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            held.valid <= 1'b0;
        end else if (load) begin
            held.valid <= 1'b1;
            held.tag   <= issue.op.tagDst;
            held.value <= compute(issue.op);
            held.nmDst <= issue.op.nmDst;
        end else if (grant) begin
            held.valid <= 1'b0;  // Word taken by the arbiter
        end
    end

    assign req    = held.valid;  // Request from the cycle after load
    assign result = held;

endmodule

/* rtl/ReservationStation.sv */
`timescale 1ns/1ps
`include "cluster_config.svh"

module ReservationStation (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  ExecPkg::MicroOp inOp,
    ResultBusIf.listener    bus,
    IssueIf.station         issue,
    output logic            creditReturn
);

    localparam int IDX_W = $clog2(`RS_SIZE);

    ExecPkg::MicroOp intake;              // Op sampled from the dispatcher
    ExecPkg::MicroOp slots [`RS_SIZE];

    logic [IDX_W-1:0] issueIdx;
    logic             issueHit;
    logic [IDX_W-1:0] freeIdx;
    logic             issueFire;

    // Capture a matching broadcast into either operand
    function automatic ExecPkg::MicroOp snoop(
        input ExecPkg::MicroOp    op,
        input ExecPkg::ResultWord w
    );
        ExecPkg::MicroOp res;
        res = op;
        if (w.valid && op.tagA != '0 && op.tagA == w.tag) begin
            res.tagA = '0;
            res.srcA = w.value;
        end
        if (w.valid && op.tagB != '0 && op.tagB == w.tag) begin
            res.tagB = '0;
            res.srcB = w.value;
        end
        return res;
    endfunction

    // ################################################
    // Slot selection

    // Lowest slot with both operands present
    always_comb begin
        issueHit = 1'b0;
        issueIdx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (slots[i].valid && slots[i].tagA == '0 && slots[i].tagB == '0) begin
                issueHit = 1'b1;
                issueIdx = i[IDX_W-1:0];
            end
        end
    end

    // Lowest empty slot, credits guarantee one exists when intake is valid
    always_comb begin
        freeIdx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!slots[i].valid)
                freeIdx = i[IDX_W-1:0];
        end
    end

    assign issue.valid = issueHit;
    assign issue.op    = slots[issueIdx];
    assign issueFire   = issue.valid && issue.ready;

    // ################################################
    // Intake, wakeup and slot write

    always_ff @(posedge clk) begin
        if (rst) begin
            intake.valid <= 1'b0;
            for (int i = 0; i < `RS_SIZE; i++)
                slots[i].valid <= 1'b0;
            creditReturn <= 1'b0;
        end else begin
            // Forward a result broadcast in the issue cycle
            intake       <= snoop(inOp, bus.word);
            intake.valid <= inValid;

            // Waiting slots pick up operands from the bus
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (slots[i].valid)
                    slots[i] <= snoop(slots[i], bus.word);
            end

            if (issueFire)
                slots[issueIdx].valid <= 1'b0;  // Freed at the transfer edge

            // Intake also watches the bus during its own cycle
            if (intake.valid)
                slots[freeIdx] <= snoop(intake, bus.word);

            creditReturn <= issueFire;  // One credit per freed entry
        end
    end

endmodule

/* rtl/IssueIf.sv */
`timescale 1ns/1ps

// Station to ALU handshake, transfer on valid and ready
interface IssueIf;

    logic            valid;
    ExecPkg::MicroOp op;
    logic            ready;

    // Reservation station side
    modport station (
        output valid,
        output op,
        input  ready
    );

    // ALU side
    modport alu (
        input  valid,
        input  op,
        output ready
    );

endinterface

/* rtl/ResultBusIf.sv */
`timescale 1ns/1ps

// Common result bus, broadcast to every station
interface ResultBusIf;

    ExecPkg::ResultWord word;  // valid high for one cycle per result

    // Arbiter side
    modport driver (
        output word
    );

    // Stations and top-level result ports
    modport listener (
        input word
    );

endinterface

/* rtl/ExecPkg.sv */
`include "cluster_config.svh"

package ExecPkg;

    localparam int NM_WIDTH = $clog2(`NUM_ARCH_REGS);  // 5 bits for 32 regs

    // Integer ops handled by the ALUs
    typedef enum logic [5:0] {
        OpAdd    = 6'd0,
        OpSub    = 6'd1,
        OpAnd    = 6'd2,
        OpOr     = 6'd3,
        OpXor    = 6'd4,
        OpShl    = 6'd5,
        OpShr    = 6'd6,
        OpAddImm = 6'd7
    } OpCode;

    // One micro-op as held in a station slot
    typedef struct packed {
        logic                   valid;
        OpCode                  opcode;
        logic [`TAG_WIDTH-1:0]  tagA;    // Nonzero while srcA is pending
        logic [`DATA_WIDTH-1:0] srcA;
        logic [`TAG_WIDTH-1:0]  tagB;
        logic [`DATA_WIDTH-1:0] srcB;
        logic [`DATA_WIDTH-1:0] imm;
        logic [`TAG_WIDTH-1:0]  tagDst;
        logic [NM_WIDTH-1:0]    nmDst;
    } MicroOp;

    // Word on the common result bus
    typedef struct packed {
        logic                   valid;
        logic [`TAG_WIDTH-1:0]  tag;
        logic [`DATA_WIDTH-1:0] value;
        logic [NM_WIDTH-1:0]    nmDst;
    } ResultWord;

endpackage

/* rtl/cluster_config.svh */
`ifndef CLUSTER_CONFIG_SVH
`define CLUSTER_CONFIG_SVH

// Entries per reservation station, also the initial credit count
`define RS_SIZE 4

// Result tag width, tag 0 marks a ready operand
`define TAG_WIDTH 6

// Operand and result width
`define DATA_WIDTH 32

// Architectural destinations
`define NUM_ARCH_REGS 32

`endif
